// File: logic/acc_writer.sv
`timescale 1ns/1ps
`default_nettype none

module acc_writer (
	input logic dspif,
	input logic rst_n,
	input logic resetacc,
	input dsp_pkg::acc_result_t result [dsp_pkg::NCHAN],
	output dsp_pkg::acc_wr_t wr [dsp_pkg::NCHAN]
);

	// one write port per channel
	for (genvar i = 0; i < dsp_pkg::NCHAN; i++) begin : g_chan
		logic we;
		logic [dsp_pkg::ACC_ADDR_W-1:0] addr;
		logic [dsp_pkg::ACC_W-1:0] data;
		logic last;

		// last entry reached
		assign last = &addr;

		always_ff @(posedge dspif) begin
			if (!rst_n) begin
				we <= 1'b0;
				addr <= '0;
			end else begin
				// strobe delayed one cycle
				we <= result[i].valid;
				// resetacc is a level and wins over the write
				if (resetacc) begin
					addr <= '0;
				end else if (we && !last) begin
					addr <= addr + 1'b1;
				end
			end
		end

		// hold data between strobes
		always_ff @(posedge dspif) begin
			if (result[i].valid) begin
				data <= result[i].value;
			end
		end

		// address goes out with the write that uses it
		assign wr[i] = '{we: we, addr: addr, data: data};
	end

endmodule

`default_nettype wire

// File: logic/channel_core.sv
`timescale 1ns/1ps
`default_nettype none

module channel_core (
	input logic dspif,
	input logic rst_n,
	input logic core_reset,
	input logic signed [dsp_pkg::SAMPLE_W-1:0] sample,
	output logic [dsp_pkg::CMD_ADDR_W-1:0] cmd_addr,
	input dsp_pkg::cmd_t cmd,
	output dsp_pkg::acc_result_t result,
	output logic procdone,
	output logic nobusy
);

	// fetch, load, decode, then run
	typedef enum logic [2:0] {
		C_FETCH = 3'd0,
		C_LOAD  = 3'd1,
		C_EXEC  = 3'd2,
		C_WAIT  = 3'd3,
		C_MIX   = 3'd4,
		C_END   = 3'd5
	} chan_state_t;

	chan_state_t state;
	logic [dsp_pkg::CMD_ADDR_W-1:0] pc;
	dsp_pkg::cmd_t cmd_r;
	logic [dsp_pkg::LEN_W-1:0] len_cnt;
	logic mix_first;
	logic issue;
	logic issue_last;
	logic signed [dsp_pkg::PROD_W-1:0] prod;
	logic signed [dsp_pkg::ACC_W-1:0] prod_ext;
	logic prod_valid;
	logic prod_first;
	logic prod_last;
	logic signed [dsp_pkg::ACC_W-1:0] acc;
	logic acc_valid;

	// memory sees the pc directly
	assign cmd_addr = pc;

	// one sample per cycle while mixing
	assign issue = (state == C_MIX);
	assign issue_last = (len_cnt == '0);

	// sign extend into accumulator width
	assign prod_ext = prod;

	always_ff @(posedge dspif) begin
		if (!rst_n || core_reset) begin
			state <= C_FETCH;
			pc <= '0;
			len_cnt <= '0;
			mix_first <= 1'b0;
			procdone <= 1'b0;
		end else begin
			case (state)
				// address out this cycle
				C_FETCH: state <= C_LOAD;
				// memory data arrives, step pc
				C_LOAD: begin
					pc <= pc + 1'b1;
					state <= C_EXEC;
				end
				C_EXEC: begin
					// zero length runs as one cycle
					len_cnt <= (cmd_r.length == '0) ? '0 : cmd_r.length - 1'b1;
					mix_first <= 1'b1;
					case (cmd_r.opcode)
						dsp_pkg::OP_WAIT: state <= C_WAIT;
						dsp_pkg::OP_MIX: state <= C_MIX;
						dsp_pkg::OP_END: begin
							state <= C_END;
							procdone <= 1'b1;
						end
						// undefined opcode skipped
						default: state <= C_FETCH;
					endcase
				end
				C_WAIT, C_MIX: begin
					mix_first <= 1'b0;
					if (len_cnt == '0) begin
						state <= C_FETCH;
					end else begin
						len_cnt <= len_cnt - 1'b1;
					end
				end
				// parked until core_reset
				default: state <= C_END;
			endcase
		end
	end

	// command word capture
	always_ff @(posedge dspif) begin
		if (state == C_LOAD) begin
			cmd_r <= cmd;
		end
	end

	// pipeline flags, core_reset leaves them running
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			prod_valid <= issue;
			prod_first <= issue && mix_first;
			prod_last <= issue && issue_last;
			// strobe lands with the final sum
			acc_valid <= prod_valid && prod_last;
		end
	end

	// multiply then accumulate
	always_ff @(posedge dspif) begin
		if (issue) begin
			prod <= sample * cmd_r.coef;
		end
		if (prod_valid) begin
			// first product restarts the sum
			acc <= prod_first ? prod_ext : acc + prod_ext;
		end
	end

	assign result = '{valid: acc_valid, value: acc};

	// busy while anything is in the multiply or add stage
	assign nobusy = !(issue || prod_valid || acc_valid);

endmodule

`default_nettype wire

// File: logic/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	// channel and adc counts
	localparam int NCHAN = 4;
	localparam int NADC = 2;

	// datapath widths
	localparam int SAMPLE_W = 16;
	localparam int COEF_W = 8;
	localparam int LEN_W = 8;
	localparam int PROD_W = SAMPLE_W + COEF_W;
	// 255 products of 24 bits stay well inside 32 bits
	localparam int ACC_W = 32;

	// address and counter widths
	localparam int CMD_ADDR_W = 4;
	localparam int ACC_ADDR_W = 6;
	localparam int SHOT_W = 32;

	// command opcodes
	typedef enum logic [1:0] {
		OP_WAIT = 2'd0,
		OP_MIX  = 2'd1,
		OP_END  = 2'd2
	} opcode_t;

	// mix bus sources
	typedef enum logic [1:0] {
		SRC_ADC0 = 2'd0,
		SRC_ADC1 = 2'd1,
		SRC_ZERO = 2'd2
	} sample_src_t;

	// shot sequencer states, gray-ish walk through the loop
	typedef enum logic [3:0] {
		IDLE     = 4'b0000,
		START    = 4'b0001,
		PROCRUN  = 4'b0011,
		ELEMBUSY = 4'b0010,
		MORESHOT = 4'b0110,
		SHOTADD  = 4'b0111,
		DONE     = 4'b0101
	} seq_state_t;

	// one command memory word
	typedef struct packed {
		opcode_t opcode;
		logic [LEN_W-1:0] length;
		logic signed [COEF_W-1:0] coef;
	} cmd_t;

	// finished accumulation with its strobe
	typedef struct packed {
		logic valid;
		logic signed [ACC_W-1:0] value;
	} acc_result_t;

	// one accumulation buffer write
	typedef struct packed {
		logic we;
		logic [ACC_ADDR_W-1:0] addr;
		logic [ACC_W-1:0] data;
	} acc_wr_t;

	// selected samples for the two channel groups
	typedef struct packed {
		logic signed [SAMPLE_W-1:0] bus_a;
		logic signed [SAMPLE_W-1:0] bus_b;
	} mix_bus_t;

endpackage

`default_nettype wire

// File: logic/dsp_top.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_top (
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input logic [dsp_pkg::SHOT_W-1:0] nshot,
	input logic resetacc,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc [dsp_pkg::NADC],
	input dsp_pkg::sample_src_t sel_a,
	input dsp_pkg::sample_src_t sel_b,
	output logic [dsp_pkg::CMD_ADDR_W-1:0] cmd_addr [dsp_pkg::NCHAN],
	input dsp_pkg::cmd_t cmd [dsp_pkg::NCHAN],
	output dsp_pkg::acc_wr_t wr [dsp_pkg::NCHAN],
	output logic [dsp_pkg::SHOT_W-1:0] shotcnt,
	output logic lastshotdone
);

	dsp_pkg::mix_bus_t mix;
	dsp_pkg::acc_result_t result [dsp_pkg::NCHAN];
	wire [dsp_pkg::NCHAN-1:0] procdone;
	wire [dsp_pkg::NCHAN-1:0] nobusy;
	wire core_reset;

	// feeder for the channel array
	sample_select u_select (
		.dspif (dspif),
		.rst_n (rst_n),
		.adc   (adc),
		.sel_a (sel_a),
		.sel_b (sel_b),
		.mix   (mix)
	);

	for (genvar i = 0; i < dsp_pkg::NCHAN; i++) begin : g_chan
		logic signed [dsp_pkg::SAMPLE_W-1:0] chan_sample;

		// lower half on bus a, upper half on bus b
		assign chan_sample = (i < dsp_pkg::NCHAN / 2) ? mix.bus_a : mix.bus_b;

		channel_core u_core (
			.dspif      (dspif),
			.rst_n      (rst_n),
			.core_reset (core_reset),
			.sample     (chan_sample),
			.cmd_addr   (cmd_addr[i]),
			.cmd        (cmd[i]),
			.result     (result[i]),
			.procdone   (procdone[i]),
			.nobusy     (nobusy[i])
		);
	end

	// drain into the buffer ports
	acc_writer u_writer (
		.dspif    (dspif),
		.rst_n    (rst_n),
		.resetacc (resetacc),
		.result   (result),
		.wr       (wr)
	);

	// single reset level broadcast to all channels
	shot_sequencer u_seq (
		.dspif        (dspif),
		.rst_n        (rst_n),
		.stb_start    (stb_start),
		.nshot        (nshot),
		.procdone     (procdone),
		.nobusy       (nobusy),
		.core_reset   (core_reset),
		.shotcnt      (shotcnt),
		.lastshotdone (lastshotdone)
	);

endmodule

`default_nettype wire

// File: logic/sample_select.sv
`timescale 1ns/1ps
`default_nettype none

module sample_select (
	input logic dspif,
	input logic rst_n,
	input logic [dsp_pkg::SAMPLE_W-1:0] adc [dsp_pkg::NADC],
	input dsp_pkg::sample_src_t sel_a,
	input dsp_pkg::sample_src_t sel_b,
	output dsp_pkg::mix_bus_t mix
);

	// adc capture stage
	logic [dsp_pkg::SAMPLE_W-1:0] adc_r [dsp_pkg::NADC];

	// source mux shared by both buses
	function automatic logic [dsp_pkg::SAMPLE_W-1:0] pick(input dsp_pkg::sample_src_t sel);
		logic [dsp_pkg::SAMPLE_W-1:0] s;
		case (sel)
			dsp_pkg::SRC_ADC0: s = adc_r[0];
			dsp_pkg::SRC_ADC1: s = adc_r[1];
			// zero and unused codes
			default: s = '0;
		endcase
		return s;
	endfunction

	// first cycle, register raw samples
	always_ff @(posedge dspif) begin
		for (int i = 0; i < dsp_pkg::NADC; i++) begin
			adc_r[i] <= adc[i];
		end
	end

	// second cycle, registered bus select
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			mix <= '0;
		end else begin
			mix.bus_a <= pick(sel_a);
			mix.bus_b <= pick(sel_b);
		end
	end

endmodule

`default_nettype wire

// File: logic/shot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module shot_sequencer (
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input logic [dsp_pkg::SHOT_W-1:0] nshot,
	input logic [dsp_pkg::NCHAN-1:0] procdone,
	input logic [dsp_pkg::NCHAN-1:0] nobusy,
	output logic core_reset,
	output logic [dsp_pkg::SHOT_W-1:0] shotcnt,
	output logic lastshotdone
);

	dsp_pkg::seq_state_t state;
	dsp_pkg::seq_state_t next_state;
	logic [dsp_pkg::SHOT_W-1:0] nshot_r;
	logic [dsp_pkg::SHOT_W-1:0] shot_idx;
	logic [dsp_pkg::SHOT_W-1:0] next_idx;
	logic shotadd;
	logic procdone_r;
	logic nobusy_r;

	// channel status reduced and registered
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			procdone_r <= 1'b0;
			nobusy_r <= 1'b0;
		end else begin
			procdone_r <= &procdone;
			nobusy_r <= &nobusy;
		end
	end

	// next shot decision, settled long before MORESHOT
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			next_idx <= '0;
			shotadd <= 1'b0;
		end else begin
			next_idx <= shot_idx + 1'b1;
			// zero count repeats forever
			shotadd <= (next_idx != nshot_r) || (nshot_r == '0);
		end
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= dsp_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = dsp_pkg::IDLE;
		case (state)
			dsp_pkg::IDLE: next_state = stb_start ? dsp_pkg::START : dsp_pkg::IDLE;
			dsp_pkg::START: next_state = dsp_pkg::PROCRUN;
			// wait for every program to hit OP_END
			dsp_pkg::PROCRUN: next_state = procdone_r ? dsp_pkg::ELEMBUSY : dsp_pkg::PROCRUN;
			// then for the pipelines to drain
			dsp_pkg::ELEMBUSY: next_state = nobusy_r ? dsp_pkg::MORESHOT : dsp_pkg::ELEMBUSY;
			dsp_pkg::MORESHOT: next_state = shotadd ? dsp_pkg::SHOTADD : dsp_pkg::DONE;
			dsp_pkg::SHOTADD: next_state = dsp_pkg::START;
			dsp_pkg::DONE: next_state = dsp_pkg::IDLE;
			default: next_state = dsp_pkg::IDLE;
		endcase
	end

	// outputs registered from next_state so they line up with state
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			core_reset <= 1'b1;
			lastshotdone <= 1'b0;
			shot_idx <= '0;
			shotcnt <= '0;
			nshot_r <= nshot;
		end else begin
			// channels only run in START and PROCRUN
			core_reset <= !(next_state == dsp_pkg::START || next_state == dsp_pkg::PROCRUN);
			lastshotdone <= (next_state == dsp_pkg::DONE);
			case (next_state)
				dsp_pkg::IDLE: begin
					shot_idx <= '0;
					// shot count sampled only while idle
					nshot_r <= nshot;
				end
				dsp_pkg::SHOTADD: begin
					shot_idx <= next_idx;
					// index of the shot just finished
					shotcnt <= shot_idx;
				end
				dsp_pkg::DONE: shot_idx <= '0;
				default: shot_idx <= shot_idx;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb.f
logic/dsp_pkg.sv
logic/sample_select.sv
logic/channel_core.sv
logic/acc_writer.sv
logic/shot_sequencer.sv
logic/dsp_top.sv
tb/cmd_mem_model.sv
tb/tb_dsp.sv

// File: tb/cmd_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_mem_model (
	input logic dspif,
	input logic load_en,
	input logic [$clog2(dsp_pkg::NCHAN)-1:0] load_chan,
	input logic [dsp_pkg::CMD_ADDR_W-1:0] load_addr,
	input dsp_pkg::cmd_t load_data,
	input logic [dsp_pkg::CMD_ADDR_W-1:0] rd_addr [dsp_pkg::NCHAN],
	output dsp_pkg::cmd_t rd_data [dsp_pkg::NCHAN]
);

	// one program image per channel
	dsp_pkg::cmd_t mem [dsp_pkg::NCHAN][2**dsp_pkg::CMD_ADDR_W];

	// loader port, written while the channels sit in core reset
	always_ff @(posedge dspif) begin
		if (load_en) begin
			mem[load_chan][load_addr] <= load_data;
		end
	end

	// registered read, data one cycle behind the address
	always_ff @(posedge dspif) begin
		for (int i = 0; i < dsp_pkg::NCHAN; i++) begin
			rd_data[i] <= mem[i][rd_addr[i]];
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_dsp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dsp;

	logic dspif;
	logic rst_n;
	logic stb_start;
	logic [dsp_pkg::SHOT_W-1:0] nshot;
	logic resetacc;
	logic [dsp_pkg::SAMPLE_W-1:0] adc [dsp_pkg::NADC];
	dsp_pkg::sample_src_t sel_a;
	dsp_pkg::sample_src_t sel_b;
	logic [dsp_pkg::CMD_ADDR_W-1:0] cmd_addr [dsp_pkg::NCHAN];
	dsp_pkg::cmd_t cmd [dsp_pkg::NCHAN];
	dsp_pkg::acc_wr_t wr [dsp_pkg::NCHAN];
	logic [dsp_pkg::SHOT_W-1:0] shotcnt;
	logic lastshotdone;

	// program loader
	logic load_en;
	logic [$clog2(dsp_pkg::NCHAN)-1:0] load_chan;
	logic [dsp_pkg::CMD_ADDR_W-1:0] load_addr;
	dsp_pkg::cmd_t load_data;

	// programs as loaded, expected mix commands and observed buffer
	dsp_pkg::cmd_t prog [dsp_pkg::NCHAN][2**dsp_pkg::CMD_ADDR_W];
	dsp_pkg::cmd_t exp_cmd [dsp_pkg::NCHAN][2**dsp_pkg::ACC_ADDR_W * 2];
	int exp_head [dsp_pkg::NCHAN];
	int exp_tail [dsp_pkg::NCHAN];
	int wcount [dsp_pkg::NCHAN];
	logic [dsp_pkg::ACC_W-1:0] buf_mem [dsp_pkg::NCHAN][2**dsp_pkg::ACC_ADDR_W];

	logic [31:0] rng_state = 32'h42d2c389;
	int done_pulses = 0;
	int mismatches = 0;
	int other_errors = 0;
	int timeouts = 0;
	logic timed_out = 1'b0;

	dsp_top dut (
		.dspif        (dspif),
		.rst_n        (rst_n),
		.stb_start    (stb_start),
		.nshot        (nshot),
		.resetacc     (resetacc),
		.adc          (adc),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.cmd_addr     (cmd_addr),
		.cmd          (cmd),
		.wr           (wr),
		.shotcnt      (shotcnt),
		.lastshotdone (lastshotdone)
	);

	cmd_mem_model cmd_mem (
		.dspif     (dspif),
		.load_en   (load_en),
		.load_chan (load_chan),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_addr   (cmd_addr),
		.rd_data   (cmd)
	);

	initial begin
		dspif = 1'b0;
		forever #2 dspif = ~dspif;
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic dsp_pkg::cmd_t make_cmd(input dsp_pkg::opcode_t op, input logic [31:0] r);
		dsp_pkg::cmd_t w;
		w.opcode = op;
		// short waits, mixes up to 63 samples, zero now and then
		w.length = (op == dsp_pkg::OP_WAIT) ? r[3:0] : r[5:0];
		w.coef = r[15:8];
		return w;
	endfunction

	// reference model: length x selected sample x coef at the capped write count
	function automatic dsp_pkg::acc_wr_t expected_write(input int c, input dsp_pkg::cmd_t w,
		input int count);
		dsp_pkg::acc_wr_t res;
		dsp_pkg::sample_src_t sel;
		logic signed [dsp_pkg::SAMPLE_W-1:0] s;
		longint len;
		longint prod;
		sel = (c < dsp_pkg::NCHAN / 2) ? sel_a : sel_b;
		case (sel)
			dsp_pkg::SRC_ADC0: s = adc[0];
			dsp_pkg::SRC_ADC1: s = adc[1];
			default: s = '0;
		endcase
		// zero length counts as one sample
		len = (w.length == 0) ? 1 : w.length;
		prod = len * longint'($signed(s)) * longint'($signed(w.coef));
		res.we = 1'b1;
		res.addr = (count > 2**dsp_pkg::ACC_ADDR_W - 1) ? 2**dsp_pkg::ACC_ADDR_W - 1 : count;
		res.data = prod[dsp_pkg::ACC_W-1:0];
		return res;
	endfunction

	function automatic int mixes_in(input int c);
		int n;
		n = 0;
		for (int a = 0; a < 2**dsp_pkg::CMD_ADDR_W && prog[c][a].opcode != dsp_pkg::OP_END; a++) begin
			if (prog[c][a].opcode == dsp_pkg::OP_MIX) begin
				n++;
			end
		end
		return n;
	endfunction

	// true once every channel has gone past four shots of writes
	function automatic logic past_four_shots();
		logic ok;
		ok = 1'b1;
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			if (exp_head[c] <= 4 * mixes_in(c)) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// compare one buffer write against the head of its queue
	task automatic check_write(input int c);
		dsp_pkg::acc_wr_t want;
		if (exp_head[c] >= exp_tail[c]) begin
			$display("unexpected write on channel %0d at %0t, addr %0d", c, $time, wr[c].addr);
			other_errors++;
		end else begin
			want = expected_write(c, exp_cmd[c][exp_head[c]], wcount[c]);
			if (wr[c].addr != want.addr || wr[c].data != want.data) begin
				$display("mismatch at %0t: channel %0d got addr %0d data %0h, expected addr %0d data %0h",
					$time, c, wr[c].addr, wr[c].data, want.addr, want.data);
				mismatches++;
			end
			exp_head[c]++;
		end
		wcount[c]++;
		buf_mem[c][wr[c].addr] = wr[c].data;
	endtask

	// outputs are registered, so mid cycle they are settled
	always @(negedge dspif) begin
		if (lastshotdone) begin
			done_pulses++;
		end
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			if (wr[c].we) begin
				check_write(c);
			end
		end
	end

	task automatic clear_expected();
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			exp_head[c] = 0;
			exp_tail[c] = 0;
		end
	endtask

	task automatic clear_counts();
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			wcount[c] = 0;
		end
	endtask

	// one wait first, then mixes with waits sprinkled in, END padding
	task automatic make_program(input int c, input int nmix);
		logic [31:0] r;
		int a;
		int left;
		a = 0;
		left = nmix;
		r = next_rand();
		prog[c][a] = make_cmd(dsp_pkg::OP_WAIT, r);
		a++;
		while (left > 0) begin
			r = next_rand();
			if (r[31] && a + left < 2**dsp_pkg::CMD_ADDR_W - 1) begin
				prog[c][a] = make_cmd(dsp_pkg::OP_WAIT, r);
				a++;
			end
			r = next_rand();
			prog[c][a] = make_cmd(dsp_pkg::OP_MIX, r);
			a++;
			left--;
		end
		while (a < 2**dsp_pkg::CMD_ADDR_W) begin
			prog[c][a] = make_cmd(dsp_pkg::OP_END, 32'd0);
			a++;
		end
	endtask

	// new random programs for all channels, written through the loader
	task automatic new_programs(input int nmin, input int span);
		logic [31:0] r;
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			r = next_rand();
			make_program(c, nmin + int'(r % span));
		end
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			for (int a = 0; a < 2**dsp_pkg::CMD_ADDR_W; a++) begin
				@(negedge dspif);
				load_en = 1'b1;
				load_chan = c;
				load_addr = a;
				load_data = prog[c][a];
			end
		end
		@(negedge dspif);
		load_en = 1'b0;
	endtask

	task automatic set_inputs(input dsp_pkg::sample_src_t a, input dsp_pkg::sample_src_t b);
		logic [31:0] r;
		r = next_rand();
		@(negedge dspif);
		sel_a = a;
		sel_b = b;
		adc[0] = r[15:0];
		adc[1] = r[31:16];
	endtask

	task automatic push_expected(input int shots);
		for (int s = 0; s < shots; s++) begin
			for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
				for (int a = 0; a < 2**dsp_pkg::CMD_ADDR_W; a++) begin
					if (prog[c][a].opcode == dsp_pkg::OP_MIX && exp_tail[c] < 2**dsp_pkg::ACC_ADDR_W * 2) begin
						exp_cmd[c][exp_tail[c]] = prog[c][a];
						exp_tail[c]++;
					end
				end
			end
		end
	endtask

	task automatic start_shots(input int shots);
		nshot = shots;
		done_pulses = 0;
		// mix bus needs two cycles, nshot is latched while idle
		repeat (3) @(negedge dspif);
		stb_start = 1'b1;
		@(negedge dspif);
		stb_start = 1'b0;
	endtask

	task automatic check_quiet(input int ncycles, input string what);
		for (int n = 0; n < ncycles; n++) begin
			@(negedge dspif);
			if (lastshotdone) begin
				$display("lastshotdone went high %s at %0t", what, $time);
				other_errors++;
			end
			for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
				if (wr[c].we) begin
					$display("write on channel %0d %s at %0t", c, what, $time);
					other_errors++;
				end
			end
		end
	endtask

	// finite run, checked once lastshotdone shows up
	task automatic run_shots(input int shots, input logic clear_addr);
		int cycles;
		if (!timed_out) begin
			clear_expected();
			if (clear_addr) begin
				@(negedge dspif);
				resetacc = 1'b1;
				@(negedge dspif);
				resetacc = 1'b0;
				clear_counts();
			end
			push_expected(shots);
			start_shots(shots);
			cycles = 0;
			while (!lastshotdone && cycles < 20000) begin
				@(negedge dspif);
				cycles++;
			end
			if (!lastshotdone) begin
				$display("timeout: no lastshotdone after %0d cycles of a %0d shot run", cycles, shots);
				timeouts++;
				timed_out = 1'b1;
			end else begin
				// watch a few more cycles for a second pulse
				repeat (4) @(negedge dspif);
				if (done_pulses != 1) begin
					$display("lastshotdone pulsed %0d times in a %0d shot run", done_pulses, shots);
					other_errors++;
				end
				for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
					if (exp_head[c] != exp_tail[c]) begin
						$display("channel %0d is missing %0d writes", c, exp_tail[c] - exp_head[c]);
						other_errors++;
					end
				end
				if (shots >= 2 && shotcnt != shots - 2) begin
					$display("mismatch at %0t: shotcnt %0d, expected %0d", $time, shotcnt, shots - 2);
					mismatches++;
				end
			end
		end
	endtask

	// the entry left at the locked address must be the last result
	task automatic check_locked_entry();
		dsp_pkg::acc_wr_t last;
		for (int c = 0; c < dsp_pkg::NCHAN; c++) begin
			last = expected_write(c, exp_cmd[c][exp_tail[c] - 1], exp_tail[c]);
			if (buf_mem[c][2**dsp_pkg::ACC_ADDR_W - 1] != last.data) begin
				$display("mismatch at %0t: channel %0d last entry %0h, expected %0h", $time, c,
					buf_mem[c][2**dsp_pkg::ACC_ADDR_W - 1], last.data);
				mismatches++;
			end
		end
	endtask

	// nshot of zero, stopped by a DUT reset
	task automatic run_endless();
		int cycles;
		if (!timed_out) begin
			clear_expected();
			push_expected(8);
			start_shots(0);
			cycles = 0;
			while (!past_four_shots() && cycles < 20000) begin
				@(negedge dspif);
				cycles++;
			end
			if (!past_four_shots()) begin
				$display("timeout: endless run did not get past four shots in %0d cycles", cycles);
				timeouts++;
				timed_out = 1'b1;
			end else begin
				if (done_pulses != 0) begin
					$display("lastshotdone pulsed %0d times in endless mode", done_pulses);
					other_errors++;
				end
				rst_n = 1'b0;
				repeat (10) @(negedge dspif);
				clear_expected();
				clear_counts();
				rst_n = 1'b1;
				check_quiet(60, "after reset of the endless run");
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		resetacc = 1'b0;
		adc[0] = '0;
		adc[1] = '0;
		sel_a = dsp_pkg::SRC_ADC0;
		sel_b = dsp_pkg::SRC_ADC1;
		load_en = 1'b0;
		load_chan = '0;
		load_addr = '0;
		load_data = '0;
		clear_expected();
		clear_counts();
		repeat (10) @(negedge dspif);
		rst_n = 1'b1;

		// idle with live adc inputs
		set_inputs(dsp_pkg::SRC_ADC0, dsp_pkg::SRC_ADC1);
		check_quiet(30, "before stb_start");

		// single shots over the bus source combinations
		new_programs(3, 4);
		run_shots(1, 1'b0);
		set_inputs(dsp_pkg::SRC_ADC1, dsp_pkg::SRC_ZERO);
		run_shots(1, 1'b0);
		set_inputs(dsp_pkg::SRC_ZERO, dsp_pkg::SRC_ADC0);
		run_shots(1, 1'b0);
		set_inputs(dsp_pkg::SRC_ADC1, dsp_pkg::SRC_ADC1);
		run_shots(1, 1'b0);

		// three shots, same programs
		set_inputs(dsp_pkg::SRC_ADC0, dsp_pkg::SRC_ADC1);
		run_shots(3, 1'b0);

		// cleared addresses, then 70 results per channel run into the lock
		new_programs(14, 1);
		set_inputs(dsp_pkg::SRC_ADC1, dsp_pkg::SRC_ADC0);
		run_shots(5, 1'b1);
		if (!timed_out) begin
			check_locked_entry();
		end

		new_programs(3, 1);
		run_endless();

		$display("errors: %0d mismatches, %0d other, %0d timeouts", mismatches, other_errors,
			timeouts);
		if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
